// File: Bender.yml
package:
  name: color_mask

sources:
  - color_pkg.sv
  - ycc_to_rgb.sv
  - hsv_convert.sv
  - hue_window.sv
  - mask_writer.sv
  - frame_buffer.sv
  - color_mask_top.sv
  - target: test
    files:
      - tb_color_mask.sv

// File: color_mask_top.sv
`timescale 1ns/1ns
// colour mask camera pipeline
module color_mask_top
	import color_pkg::*;
#(
	parameter int PIX_PER_LINE = 8,
	parameter int LINES        = 2,
	localparam int ADDR_W      = addr_width(PIX_PER_LINE * LINES)
)
(
	input  logic              clk_llc,
	input  logic              resetx,
	input  logic              vref,
	input  logic              href,
	input  logic [7:0]        vpo,
	input  logic              host_csx,
	input  logic              host_rdx,
	input  logic [ADDR_W-1:0] host_addr,
	output class_word_t       host_rdata,
	output logic              irq_bank0,
	output logic              irq_bank1
);

	pixel_t red;
	pixel_t green;
	pixel_t blue;
	logic rgb_valid;
	pixel_t hue;
	logic black;
	logic chroma;
	logic hsv_valid;
	logic [NUM_HUES-1:0] hue_hit;
	logic [NUM_HUES-1:0] hit_valid_all; // all in step, bit 0 used
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	class_word_t wr_data;
	logic wr_bank;

	ycc_to_rgb u_ycc_to_rgb (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.href      (href),
		.vpo       (vpo),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.rgb_valid (rgb_valid)
	);

	hsv_convert u_hsv_convert (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.rgb_valid (rgb_valid),
		.hue       (hue),
		.black     (black),
		.chroma    (chroma),
		.hsv_valid (hsv_valid)
	);

	//---------------------------------------------------------------------
	// one window per class bit
	//---------------------------------------------------------------------
	for (genvar i = 0; i < NUM_HUES; i++)
	begin : g_hue
		hue_window #(
			.CENTER (HUE_CENTER[i])
		) u_hue_window (
			.clk_llc   (clk_llc),
			.resetx    (resetx),
			.hue       (hue),
			.chroma    (chroma),
			.hsv_valid (hsv_valid),
			.hit       (hue_hit[i]),
			.hit_valid (hit_valid_all[i])
		);
	end

	mask_writer #(
		.PIX_PER_LINE (PIX_PER_LINE),
		.LINES        (LINES)
	) u_mask_writer (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.vref      (vref),
		.hue_hit   (hue_hit),
		.black     (black),
		.hit_valid (hit_valid_all[0]),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_bank   (wr_bank),
		.irq_bank0 (irq_bank0),
		.irq_bank1 (irq_bank1)
	);

	frame_buffer #(
		.PIX_PER_LINE (PIX_PER_LINE),
		.LINES        (LINES)
	) u_frame_buffer (
		.clk_llc    (clk_llc),
		.resetx     (resetx),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.wr_bank    (wr_bank),
		.host_csx   (host_csx),
		.host_rdx   (host_rdx),
		.host_addr  (host_addr),
		.host_rdata (host_rdata)
	);

endmodule

// File: color_pkg.sv
// colour mask shared definitions
package color_pkg;

	typedef logic [7:0]  pixel_t;      // one colour channel or hue
	typedef logic [15:0] class_word_t; // class word stored per pixel

	//---------------------------------------------------------------------
	// ycbcr to rgb, constants in 2.8 fixed point
	//---------------------------------------------------------------------
	localparam logic [9:0] K_Y    = 10'b01_0010_1010; // 1.164
	localparam logic [9:0] K_CR_R = 10'b01_1001_1000; // 1.596
	localparam logic [9:0] K_CR_G = 10'b00_1101_0000; // 0.813
	localparam logic [9:0] K_CB_G = 10'b00_0110_0100; // 0.392
	localparam logic [9:0] K_CB_B = 10'b10_0000_0100; // 2.017

	localparam logic [9:0] Y_OFFSET = 10'd64;  // 16 << 2, luma black level
	localparam logic [9:0] C_OFFSET = 10'd512; // 128 << 2, chroma zero

	//---------------------------------------------------------------------
	// binarization thresholds
	//---------------------------------------------------------------------
	localparam pixel_t H_TOL   = 8'd10; // half width of a hue window
	localparam pixel_t S_THRES = 8'd96; // saturation above this is chromatic
	localparam pixel_t V_THRES = 8'd96; // value below this is black

	localparam int NUM_HUES = 5;

	// hue centres on the 0..239 scale, indexed by the class bit below
	localparam pixel_t HUE_CENTER [NUM_HUES] = '{8'd230, 8'd15, 8'd40, 8'd90, 8'd144};

	localparam int HUE_R = 0; // red
	localparam int HUE_O = 1; // orange
	localparam int HUE_Y = 2; // yellow
	localparam int HUE_G = 3; // green
	localparam int HUE_B = 4; // blue

	// completing byte to class flags valid
	localparam int PIPE_DEPTH = 6;

	// word address width of one frame bank
	function automatic int addr_width(input int depth);
		return (depth > 1) ? $clog2(depth) : 1;
	endfunction

endpackage

// File: frame_buffer.sv
`timescale 1ns/1ns
// two bank class word buffer
module frame_buffer
	import color_pkg::*;
#(
	parameter int PIX_PER_LINE = 8,
	parameter int LINES        = 2,
	localparam int DEPTH       = PIX_PER_LINE * LINES,
	localparam int ADDR_W      = addr_width(DEPTH)
)
(
	input  logic              clk_llc,
	input  logic              resetx,
	input  logic              wr_en,
	input  logic [ADDR_W-1:0] wr_addr,
	input  class_word_t       wr_data,
	input  logic              wr_bank,
	input  logic              host_csx,  // active low
	input  logic              host_rdx,  // active low
	input  logic [ADDR_W-1:0] host_addr,
	output class_word_t       host_rdata
);

	class_word_t mem [2][DEPTH];
	logic bank_q;      // write bank last cycle
	logic frame_seen;  // some bank completed since reset
	logic rd_ok;

	// pixel side
	always_ff @(posedge clk_llc)
	begin
		if (wr_en)
			mem[wr_bank][wr_addr] <= wr_data;
	end

	// nothing completed yet, reads give zero
	assign rd_ok = frame_seen | (bank_q ^ wr_bank);

	// host side, always the other bank
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			bank_q     <= 1'b0;
			frame_seen <= 1'b0;
			host_rdata <= '0;
		end
		else
		begin
			bank_q <= wr_bank;
			if (bank_q != wr_bank)
				frame_seen <= 1'b1;
			if (!host_csx && !host_rdx)
				host_rdata <= rd_ok ? mem[~wr_bank][host_addr] : '0;
		end
	end

endmodule

// File: hsv_convert.sv
`timescale 1ns/1ns
// rgb888 to hue and chroma flags
module hsv_convert
	import color_pkg::*;
(
	input  logic   clk_llc,
	input  logic   resetx,
	input  pixel_t red,
	input  pixel_t green,
	input  pixel_t blue,
	input  logic   rgb_valid,
	output pixel_t hue,        // 0..239
	output logic   black,
	output logic   chroma,
	output logic   hsv_valid
);

	pixel_t max_c;
	pixel_t min_c;
	logic [1:0] idx_c;         // 0 r, 1 g, 2 b
	pixel_t r_q1;
	pixel_t g_q1;
	pixel_t b_q1;
	pixel_t max_q1;
	pixel_t min_q1;
	logic [1:0] idx_q1;
	logic vld_q1;
	pixel_t delta_q2;
	logic signed [8:0] diff_q2;
	pixel_t max_q2;
	logic [1:0] idx_q2;
	logic vld_q2;
	logic signed [15:0] num_c; // 40 x difference
	logic signed [15:0] quo_c;
	logic signed [15:0] hue_s;
	logic [15:0] sat_c;
	logic black_c;

	//---------------------------------------------------------------------
	// stage 1, max / min and max channel
	//---------------------------------------------------------------------
	always_comb
	begin
		if (red >= green && red >= blue)
		begin
			max_c = red;
			idx_c = 2'd0;
		end
		else if (green >= blue)
		begin
			max_c = green;
			idx_c = 2'd1;
		end
		else
		begin
			max_c = blue;
			idx_c = 2'd2;
		end
		if (red <= green && red <= blue)
			min_c = red;
		else if (green <= blue)
			min_c = green;
		else
			min_c = blue;
	end

	always_ff @(posedge clk_llc)
	begin
		r_q1   <= red;
		g_q1   <= green;
		b_q1   <= blue;
		max_q1 <= max_c;
		min_q1 <= min_c;
		idx_q1 <= idx_c;
		// stage 2, delta and hue difference
		delta_q2 <= max_q1 - min_q1;
		max_q2   <= max_q1;
		idx_q2   <= idx_q1;
		case (idx_q1)
			2'd0:    diff_q2 <= $signed({1'b0, g_q1}) - $signed({1'b0, b_q1});
			2'd1:    diff_q2 <= $signed({1'b0, b_q1}) - $signed({1'b0, r_q1});
			default: diff_q2 <= $signed({1'b0, r_q1}) - $signed({1'b0, g_q1});
		endcase
	end

	//---------------------------------------------------------------------
	// stage 3, hue sector, saturation and value compares
	//---------------------------------------------------------------------
	always_comb
	begin
		num_c = diff_q2 * 16'sd40;
		quo_c = '0;
		hue_s = '0;                // grey has hue 0
		if (delta_q2 != 8'd0)
		begin
			quo_c = num_c / $signed({8'd0, delta_q2});
			case (idx_q2)
				2'd0:    hue_s = quo_c + 16'sd240;
				2'd1:    hue_s = quo_c + 16'sd80;
				default: hue_s = quo_c + 16'sd160;
			endcase
			if (hue_s >= 16'sd240)
				hue_s = hue_s - 16'sd240; // red sector wraps to 0
		end
	end

	assign sat_c   = (max_q2 != 8'd0) ? (16'(delta_q2) * 16'd255) / 16'(max_q2) : 16'd0;
	assign black_c = max_q2 < V_THRES;

	always_ff @(posedge clk_llc)
	begin
		hue    <= hue_s[7:0];
		black  <= black_c;
		chroma <= ~black_c & (sat_c > 16'(S_THRES));
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			vld_q1    <= 1'b0;
			vld_q2    <= 1'b0;
			hsv_valid <= 1'b0;
		end
		else
		begin
			vld_q1    <= rgb_valid;
			vld_q2    <= vld_q1;
			hsv_valid <= vld_q2;
		end
	end

endmodule

// File: hue_window.sv
`timescale 1ns/1ns
// single colour hue window
module hue_window
	import color_pkg::*;
#(
	parameter pixel_t CENTER = 8'd0
)
(
	input  logic   clk_llc,
	input  logic   resetx,
	input  pixel_t hue,
	input  logic   chroma,
	input  logic   hsv_valid,
	output logic   hit,
	output logic   hit_valid
);

	// bounds wrap in 8 bits like the threshold table
	localparam pixel_t LO = CENTER - H_TOL;
	localparam pixel_t HI = CENTER + H_TOL;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			hit       <= 1'b0;
			hit_valid <= 1'b0;
		end
		else
		begin
			hit       <= chroma & (LO < hue) & (hue < HI); // open window
			hit_valid <= hsv_valid;
		end
	end

endmodule

// File: mask_writer.sv
`timescale 1ns/1ns
// class word packer and frame bank control
module mask_writer
	import color_pkg::*;
#(
	parameter int PIX_PER_LINE = 8,
	parameter int LINES        = 2,
	localparam int DEPTH       = PIX_PER_LINE * LINES,
	localparam int ADDR_W      = addr_width(DEPTH)
)
(
	input  logic                clk_llc,
	input  logic                resetx,
	input  logic                vref,       // frame level
	input  logic [NUM_HUES-1:0] hue_hit,
	input  logic                black,
	input  logic                hit_valid,
	output logic                wr_en,
	output logic [ADDR_W-1:0]   wr_addr,
	output class_word_t         wr_data,
	output logic                wr_bank,    // bank being written
	output logic                irq_bank0,
	output logic                irq_bank1
);

	logic black_d;                 // lined up with hue_hit
	logic r_b, o_b, y_b, g_b, b_b;
	class_word_t word_c;
	logic [ADDR_W-1:0] pix_cnt;    // next pixel address
	logic vref_q;
	logic [PIPE_DEPTH:0] fe_pipe;  // falling vref, delayed
	logic frame_end;

	assign r_b = hue_hit[HUE_R];
	assign o_b = hue_hit[HUE_O];
	assign y_b = hue_hit[HUE_Y];
	assign g_b = hue_hit[HUE_G];
	assign b_b = hue_hit[HUE_B];

	// combined class bits, msb first
	assign word_c = {r_b | o_b | y_b, r_b | o_b | y_b | black_d, r_b, o_b, y_b,
		g_b | y_b, g_b | y_b | o_b | black_d, g_b | y_b | o_b, g_b, g_b, g_b,
		b_b, b_b | black_d, b_b, b_b, black_d};

	//---------------------------------------------------------------------
	// pixel writes
	//---------------------------------------------------------------------
	always_ff @(posedge clk_llc)
	begin
		black_d <= black;
		if (hit_valid)
		begin
			wr_addr <= pix_cnt;
			wr_data <= word_c;
		end
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			wr_en   <= 1'b0;
			pix_cnt <= '0;
		end
		else
		begin
			wr_en <= hit_valid;
			if (frame_end)
				pix_cnt <= '0;
			else if (hit_valid)
				pix_cnt <= (pix_cnt == ADDR_W'(DEPTH - 1)) ? '0 : pix_cnt + 1'b1;
		end
	end

	//---------------------------------------------------------------------
	// frame end, bank toggle, interrupts
	//---------------------------------------------------------------------
	assign frame_end = fe_pipe[PIPE_DEPTH]; // after the last word is written

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			vref_q    <= 1'b0;
			fe_pipe   <= '0;
			wr_bank   <= 1'b0;
			irq_bank0 <= 1'b0;
			irq_bank1 <= 1'b0;
		end
		else
		begin
			vref_q    <= vref;
			fe_pipe   <= {fe_pipe[PIPE_DEPTH-1:0], vref_q & ~vref};
			irq_bank0 <= frame_end & ~wr_bank; // bank 0 done
			irq_bank1 <= frame_end & wr_bank;
			if (frame_end)
				wr_bank <= ~wr_bank;
		end
	end

endmodule

// File: tb_color_mask.sv
// colour mask pipeline testbench
`timescale 1ns/1ns
module tb_color_mask;

	localparam int PIX_PER_LINE    = 8;
	localparam int LINES           = 2;
	localparam int N_PIX           = PIX_PER_LINE * LINES;
	localparam int ADDR_W          = $clog2(N_PIX);
	localparam int GROUPS_PER_LINE = PIX_PER_LINE / 2;  // cb y0 cr y1 = two pixels
	localparam int N_GROUPS        = 16;                 // two frames worth in the file
	localparam int IRQ_TIMEOUT     = 200;
	localparam logic [15:0] BLACK_WORD = 16'h4209;      // bits 14, 9, 3, 0

	logic              clk_llc;
	logic              resetx;
	logic              vref;
	logic              href;
	logic [7:0]        vpo;
	logic              host_csx;
	logic              host_rdx;
	logic [ADDR_W-1:0] host_addr;
	logic [15:0]       host_rdata;
	logic              irq_bank0;
	logic              irq_bank1;

	logic [15:0] stim_mem [0:N_GROUPS*6-1]; // cb y0 cr y1 w0 w1 per group
	integer seed;
	int errors;
	int checks;
	int err_before;
	logic [15:0] rd_word;

	color_mask_top #(
		.PIX_PER_LINE (PIX_PER_LINE),
		.LINES        (LINES)
	) u_color_mask_top (
		.clk_llc    (clk_llc),
		.resetx     (resetx),
		.vref       (vref),
		.href       (href),
		.vpo        (vpo),
		.host_csx   (host_csx),
		.host_rdx   (host_rdx),
		.host_addr  (host_addr),
		.host_rdata (host_rdata),
		.irq_bank0  (irq_bank0),
		.irq_bank1  (irq_bank1)
	);

	initial
	begin
		clk_llc = 1'b0;
		forever #2 clk_llc = ~clk_llc; // 4 ns period
	end

	//---------------------------------------------------------------------
	// helpers
	//---------------------------------------------------------------------
	task automatic check_word(input int addr, input logic [15:0] exp, input logic [15:0] got);
		checks++;
		if (got !== exp)
		begin
			$display("FAIL t=%0t host_rdata addr %0d expected %h got %h",
				$time, addr, exp, got);
			errors++;
		end
	endtask

	task automatic report_test(input int num, input string name, input int err_start);
		if (errors == err_start)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, errors - err_start);
	endtask

	task automatic drive_byte(input logic [7:0] b);
		@(posedge clk_llc);
		#1;
		href = 1'b1;
		vpo  = b;
	endtask

	// one video line, groups from the file
	task automatic send_line(input int first_group);
		for (int g = 0; g < GROUPS_PER_LINE; g++)
			for (int b = 0; b < 4; b++)
				drive_byte(stim_mem[(first_group + g) * 6 + b][7:0]);
		@(posedge clk_llc);
		#1;
		href = 1'b0;            // clears the byte phase
		vpo  = 8'h00;
	endtask

	task automatic start_frame();
		@(posedge clk_llc);
		#1;
		vref = 1'b1;
	endtask

	task automatic send_frame_lines(input int first_group);
		int gap;
		for (int l = 0; l < LINES; l++)
		begin
			gap = 1 + ($unsigned($random(seed)) % 4); // blanking before the line
			repeat (gap) @(posedge clk_llc);
			send_line(first_group + l * GROUPS_PER_LINE);
		end
	endtask

	task automatic end_frame();
		repeat (3) @(posedge clk_llc);
		#1;
		vref = 1'b0;
	endtask

	// strobe one cycle, data registered on the next edge
	task automatic host_read(input int addr, output logic [15:0] data);
		@(posedge clk_llc);
		#1;
		host_csx  = 1'b0;
		host_rdx  = 1'b0;
		host_addr = addr[ADDR_W-1:0];
		@(posedge clk_llc);
		#1;
		host_csx = 1'b1;
		host_rdx = 1'b1;
		data = host_rdata;
	endtask

	task automatic readback(input int first_group, input int first_addr, input int count);
		logic [15:0] got;
		logic [15:0] exp;
		int gap;
		for (int a = first_addr; a < first_addr + count; a++)
		begin
			gap = $unsigned($random(seed)) % 3;
			repeat (gap) @(posedge clk_llc);
			exp = stim_mem[(first_group + a / 2) * 6 + 4 + a % 2]; // pixel 0 then 1
			host_read(a, got);
			check_word(a, exp, got);
		end
	endtask

	// wait for one bank pulse, then watch for extras
	task automatic wait_irq(input int bank);
		int cycles;
		int hits;
		int other;
		logic seen;
		cycles = 0;
		hits   = 0;
		other  = 0;
		seen   = 1'b0;
		while (!seen && cycles < IRQ_TIMEOUT)
		begin
			@(posedge clk_llc);
			#1;
			cycles++;
			if ((bank == 0) ? irq_bank0 : irq_bank1)
			begin
				hits++;
				seen = 1'b1;
			end
			if ((bank == 0) ? irq_bank1 : irq_bank0)
				other++;
		end
		if (!seen)
		begin
			$display("irq_bank%0d did not pulse within %0d cycles", bank, IRQ_TIMEOUT);
			errors++;
		end
		else
		begin
			repeat (20)
			begin
				@(posedge clk_llc);
				#1;
				if ((bank == 0) ? irq_bank0 : irq_bank1)
					hits++;
				if ((bank == 0) ? irq_bank1 : irq_bank0)
					other++;
			end
			checks++;
			if (hits != 1)
			begin
				$display("FAIL t=%0t irq_bank%0d pulse cycles expected 1 got %0d",
					$time, bank, hits);
				errors++;
			end
			checks++;
			if (other != 0)
			begin
				$display("FAIL t=%0t irq_bank%0d pulse cycles expected 0 got %0d",
					$time, 1 - bank, other);
				errors++;
			end
		end
	endtask

	//---------------------------------------------------------------------
	// test sequence
	//---------------------------------------------------------------------
	initial
	begin
		seed      = 32'h74ada0be;
		errors    = 0;
		checks    = 0;
		resetx    = 1'b0;
		vref      = 1'b0;
		href      = 1'b0;
		vpo       = 8'h00;
		host_csx  = 1'b1;
		host_rdx  = 1'b1;
		host_addr = '0;
		$readmemh("tb_color_mask_input.txt", stim_mem);
		if (stim_mem[0] === 16'hxxxx || stim_mem[N_GROUPS*6-1] === 16'hxxxx)
		begin
			$display("stimulus file tb_color_mask_input.txt is missing or short");
			errors++;
		end
		repeat (2) @(posedge clk_llc);
		#1;
		resetx = 1'b1;

		// 1, idle state after reset
		err_before = errors;
		checks++;
		if (irq_bank0 !== 1'b0)
		begin
			$display("FAIL t=%0t irq_bank0 expected 0 got %b", $time, irq_bank0);
			errors++;
		end
		checks++;
		if (irq_bank1 !== 1'b0)
		begin
			$display("FAIL t=%0t irq_bank1 expected 0 got %b", $time, irq_bank1);
			errors++;
		end
		host_read(0, rd_word);
		check_word(0, 16'h0000, rd_word);
		report_test(1, "reset state", err_before);

		// 2, frame one into bank 0
		err_before = errors;
		start_frame();
		send_frame_lines(0);
		end_frame();
		wait_irq(0);
		readback(0, 0, N_PIX);
		report_test(2, "frame one colours", err_before);

		// 3, frame two into bank 1
		err_before = errors;
		repeat (12) @(posedge clk_llc);
		start_frame();
		send_frame_lines(8);
		end_frame();
		wait_irq(1);
		readback(8, 0, N_PIX - 4);
		report_test(3, "frame two bank alternation", err_before);

		// 4, dark and bright grey pixels at the end of frame two
		err_before = errors;
		host_read(12, rd_word);
		check_word(12, BLACK_WORD, rd_word);
		host_read(13, rd_word);
		check_word(13, 16'h0000, rd_word);   // grey, neither class
		host_read(14, rd_word);
		check_word(14, BLACK_WORD, rd_word); // saturated but too dark
		host_read(15, rd_word);
		check_word(15, 16'h0000, rd_word);
		report_test(4, "grey and dark pixels", err_before);

		// 5, host reads bank 1 while frame three fills bank 0
		err_before = errors;
		repeat (12) @(posedge clk_llc);
		start_frame();
		fork
			send_frame_lines(0);
			readback(8, 0, N_PIX);
		join
		end_frame();
		report_test(5, "reads during frame three", err_before);

		// 6, bank 0 holds frame three after it completes
		err_before = errors;
		wait_irq(0);
		readback(0, 0, N_PIX);
		report_test(6, "frame three readback", err_before);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: tb_color_mask_input.txt
// columns: cb y0 cr y1 word_pixel0 word_pixel1, all hex, one byte group per line
// lines 1-8 frame one (also replayed as frame three), lines 9-16 frame two
0077 0053 00CC 005A E000 E000
004B 0085 00BA 0078 D300 D300
0035 00AB 008C 00A0 CF00 CF00
0063 0087 0042 007D 07E0 07E0
00C0 0066 0054 005A 001E 001E
0096 0084 003E 0096 0000 0000
00C0 0078 0054 004B 001E 001E
004B 0064 00BA 0091 D300 D300
0035 00BE 008C 008C CF00 CF00
0063 0096 0042 0064 07E0 07E0
0077 003C 00CC 006E E000 E000
004B 006E 00BA 003C D300 D300
00C0 006E 0054 003C 001E 001E
0096 0064 003E 00AA 0000 0000
0080 0028 0080 00C8 4209 0000
008C 0028 0080 00D2 4209 0000

// File: verilog.f
color_pkg.sv
ycc_to_rgb.sv
hsv_convert.sv
hue_window.sv
mask_writer.sv
frame_buffer.sv
color_mask_top.sv
tb_color_mask.sv

// File: ycc_to_rgb.sv
`timescale 1ns/1ns
// ycbcr 4:2:2 to rgb888 converter
module ycc_to_rgb
	import color_pkg::*;
(
	input  logic       clk_llc,
	input  logic       resetx,
	input  logic       href,      // line level
	input  logic [7:0] vpo,       // decoder byte
	output pixel_t     red,
	output pixel_t     green,
	output pixel_t     blue,
	output logic       rgb_valid
);

	logic [1:0] phase;            // 0 cb, 1 y0, 2 cr, 3 y1
	pixel_t cb_q;
	pixel_t y0_q;
	pixel_t cr_q;
	logic pix_done;               // cr or y1 completes a pixel
	logic [9:0] y_w;              // widened operands
	logic [9:0] cb_w;
	logic [9:0] cr_w;
	logic signed [10:0] y_d;      // offset removed
	logic signed [10:0] cb_d;
	logic signed [10:0] cr_d;
	logic signed [20:0] x_p;      // luma term
	logic signed [20:0] a_p;      // cr -> r
	logic signed [20:0] b1_p;     // cr -> g
	logic signed [20:0] b2_p;     // cb -> g
	logic signed [20:0] c_p;      // cb -> b
	logic prod_valid;
	logic signed [20:0] r_s;
	logic signed [20:0] g_s;
	logic signed [20:0] b_s;

	// clip a 10 fraction bit sum to one byte
	function automatic pixel_t clip(input logic signed [20:0] v);
		if (v[20])
			return 8'd0;          // negative
		else if (v[19:18] != 2'b00)
			return 8'hff;         // overflow
		else
			return v[17:10];
	endfunction

	//---------------------------------------------------------------------
	// byte phase and capture
	//---------------------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			phase <= 2'd0;
		else if (href)
			phase <= phase + 2'd1;
		else
			phase <= 2'd0;        // low href restarts at cb
	end

	always_ff @(posedge clk_llc)
	begin
		if (href && phase == 2'd0)
			cb_q <= vpo;
		if (href && phase == 2'd1)
			y0_q <= vpo;
		if (href && phase == 2'd2)
			cr_q <= vpo;          // kept for pixel 1
	end

	assign pix_done = href & phase[1];

	// the completing byte is taken live from vpo
	assign y_w  = {(phase[0] ? vpo : y0_q), 2'b00};
	assign cb_w = {cb_q, 2'b00};
	assign cr_w = {(phase[0] ? cr_q : vpo), 2'b00};

	assign y_d  = $signed({1'b0, y_w})  - $signed({1'b0, Y_OFFSET});
	assign cb_d = $signed({1'b0, cb_w}) - $signed({1'b0, C_OFFSET});
	assign cr_d = $signed({1'b0, cr_w}) - $signed({1'b0, C_OFFSET});

	//---------------------------------------------------------------------
	// product stage, then sum and clip
	//---------------------------------------------------------------------
	always_ff @(posedge clk_llc)
	begin
		if (pix_done)
		begin
			x_p  <= $signed({1'b0, K_Y})    * y_d;
			a_p  <= $signed({1'b0, K_CR_R}) * cr_d;
			b1_p <= $signed({1'b0, K_CR_G}) * cr_d;
			b2_p <= $signed({1'b0, K_CB_G}) * cb_d;
			c_p  <= $signed({1'b0, K_CB_B}) * cb_d;
		end
		if (prod_valid)
		begin
			r_s <= x_p + a_p;
			g_s <= x_p - b1_p - b2_p;
			b_s <= x_p + c_p;
		end
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			prod_valid <= 1'b0;
			rgb_valid  <= 1'b0;
		end
		else
		begin
			prod_valid <= pix_done;
			rgb_valid  <= prod_valid;
		end
	end

	assign red   = clip(r_s);
	assign green = clip(g_s);
	assign blue  = clip(b_s);

endmodule
